// ==== autocorr.f ====
+incdir+tb
src/autocorrPkg.sv
src/hammingRom.sv
src/sampleBuffer.sv
src/autocorrSequencer.sv
src/basicOpsUnit.sv
src/coefWriter.sv
src/autocorrTop.sv
tb/autocorrTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build and run the autocorrelation testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module autocorrTb -f autocorr.f -Mdir "$BUILD_DIR" -o autocorrSim; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/autocorrSim" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
	echo "Simulation reported failures, see $LOG"
	exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== tb/autocorrRefModel.svh ====
/*
 Bit-exact model of the G.729 autocorrelation, built from the basic operations.
 Included in the testbench module; it uses frameX, expHigh, expLow and ORDER from there.
*/
`ifndef AUTOCORR_REF_MODEL_SVH
`define AUTOCORR_REF_MODEL_SVH

localparam int MODEL_LEN = 240;

// G.729 hamwindow, Q15
localparam logic signed [15:0] HAM_WINDOW [0:MODEL_LEN-1] = '{
	2621,  2623,  2629,  2638,  2651,  2668,  2689,  2713,  2741,  2772,
	2808,  2847,  2890,  2936,  2986,  3040,  3097,  3158,  3223,  3291,
	3363,  3438,  3517,  3599,  3685,  3774,  3867,  3963,  4063,  4166,
	4272,  4382,  4495,  4611,  4731,  4853,  4979,  5108,  5240,  5376,
	5514,  5655,  5800,  5947,  6097,  6250,  6406,  6565,  6726,  6890,
	7057,  7227,  7399,  7573,  7750,  7930,  8112,  8296,  8483,  8672,
	8863,  9057,  9252,  9450,  9650,  9852, 10055, 10261, 10468, 10677,
	10888, 11101, 11315, 11531, 11748, 11967, 12187, 12409, 12632, 12856,
	13082, 13308, 13536, 13764, 13994, 14225, 14456, 14688, 14921, 15155,
	15389, 15624, 15859, 16095, 16331, 16568, 16805, 17042, 17279, 17516,
	17754, 17991, 18228, 18465, 18702, 18939, 19175, 19411, 19647, 19882,
	20117, 20350, 20584, 20816, 21048, 21279, 21509, 21738, 21967, 22194,
	22420, 22644, 22868, 23090, 23311, 23531, 23749, 23965, 24181, 24394,
	24606, 24816, 25024, 25231, 25435, 25638, 25839, 26037, 26234, 26428,
	26621, 26811, 26999, 27184, 27368, 27548, 27727, 27903, 28076, 28247,
	28415, 28581, 28743, 28903, 29061, 29215, 29367, 29515, 29661, 29804,
	29944, 30081, 30214, 30345, 30472, 30597, 30718, 30836, 30950, 31062,
	31170, 31274, 31376, 31474, 31568, 31659, 31747, 31831, 31911, 31988,
	32062, 32132, 32198, 32261, 32320, 32376, 32428, 32476, 32521, 32561,
	32599, 32632, 32662, 32688, 32711, 32729, 32744, 32755, 32763, 32767,
	32767, 32741, 32665, 32537, 32359, 32129, 31850, 31521, 31143, 30716,
	30242, 29720, 29151, 28538, 27879, 27177, 26433, 25647, 24821, 23957,
	23055, 22117, 21145, 20139, 19102, 18036, 16941, 15820, 14674, 13505,
	12315, 11106,  9879,  8637,  7381,  6114,  4838,  3554,  2264,   971
};

// mult_r, (a*b + 0x4000) >> 15 saturated to 16 bits
function automatic logic signed [15:0] multRound(input logic signed [15:0] a,
		input logic signed [15:0] b);
	longint p;
	p = (longint'(a) * longint'(b) + 64'sd16384) >>> 15;
	if (p > 64'sd32767)
		p = 64'sd32767;
	return 16'(p);
endfunction

// L_mac, returns {overflow, sum}
function automatic logic [32:0] macStep(input logic signed [31:0] acc,
		input logic signed [15:0] a, input logic signed [15:0] b);
	longint prod;
	longint s;
	logic ovf;
	ovf = 1'b0;
	prod = 2 * longint'(a) * longint'(b);
	if (prod > 64'sh7FFF_FFFF)
	begin
		prod = 64'sh7FFF_FFFF;
		ovf = 1'b1;
	end
	s = longint'(acc) + prod;
	if (s > 64'sh7FFF_FFFF)
	begin
		s = 64'sh7FFF_FFFF;
		ovf = 1'b1;
	end
	else if (s < -64'sh8000_0000)
	begin
		s = -64'sh8000_0000;
		ovf = 1'b1;
	end
	return {ovf, 32'(s)};
endfunction

// norm_l
function automatic int normCount(input logic signed [31:0] v);
	longint t;
	int n;
	if (v == 0)
		return 0;
	if (v == -32'sd1)
		return 31;
	t = longint'(v);
	if (t < 0)
		t = ~t;
	n = 0;
	while (t < 64'sh4000_0000)
	begin
		t = t * 2;
		n++;
	end
	return n;
endfunction

// L_shl with saturation, n >= 0
function automatic logic signed [31:0] shlSat(input logic signed [31:0] v, input int n);
	longint t;
	t = longint'(v);
	repeat (n)
	begin
		if (t > 64'sh3FFF_FFFF)
			return 32'sh7FFF_FFFF;
		if (t < -64'sh4000_0000)
			return 32'sh8000_0000;
		t = t * 2;
	end
	return 32'(t);
endfunction

// Low half of L_Extract
function automatic logic signed [15:0] lowWord(input logic signed [31:0] v);
	longint rest;
	rest = (longint'(v) >>> 1) - longint'($signed(v[31:16])) * 32768;
	return rest[15:0];
endfunction

task automatic modelFrame();
	logic signed [15:0] y [0:MODEL_LEN-1];
	logic signed [31:0] acc;
	logic signed [31:0] scaled;
	logic [32:0] step;
	logic ovf;
	int norm;
	for (int n = 0; n < MODEL_LEN; n++)
		y[n] = multRound(frameX[n], HAM_WINDOW[n]);
	// Energy passes, y quartered after every saturated one
	do
	begin
		ovf = 1'b0;
		acc = 32'sd1;
		for (int n = 0; n < MODEL_LEN; n++)
		begin
			step = macStep(acc, y[n], y[n]);
			ovf = ovf | step[32];
			acc = step[31:0];
		end
		if (ovf)
			for (int n = 0; n < MODEL_LEN; n++)
				y[n] = y[n] >>> 2;
	end
	while (ovf);
	norm = normCount(acc);
	for (int lag = 0; lag <= ORDER; lag++)
	begin
		if (lag > 0)
		begin
			acc = '0;
			for (int n = 0; n < MODEL_LEN - lag; n++)
			begin
				step = macStep(acc, y[n], y[n + lag]);
				acc = step[31:0];
			end
		end
		scaled = shlSat(acc, norm);      // Same norm for every lag
		expHigh[lag] = scaled[31:16];
		expLow[lag] = lowWord(scaled);
	end
endtask

`endif

// ==== tb/autocorrTb.sv ====
/*
 Testbench for autocorrTop with ORDER 10. Frames come from a case table, expected
 banks from the model in autocorrRefModel.svh. Inputs change on the rising edge,
 outputs are sampled on the falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module autocorrTb;

	localparam int ORDER = 10;
	localparam int NUM_TESTS = 5;
	localparam int CYCLES_PER_TEST = 120000;   // Worst case frame incl. rescale passes
	localparam int CYCLE_LIMIT = NUM_TESTS * CYCLES_PER_TEST;
	localparam int WLEN = autocorrPkg::WINDOW_LEN;
	localparam int AW = autocorrPkg::ADDR_W;
	localparam int CW = autocorrPkg::COEF_ADDR_W;

	localparam logic [1:0] KIND_ZERO = 2'd0;
	localparam logic [1:0] KIND_RANDOM = 2'd1;
	localparam logic [1:0] KIND_ALTERNATE = 2'd2;
	localparam logic [1:0] KIND_CONST = 2'd3;

	typedef struct packed {
		logic [1:0]  kind;
		logic [15:0] level;      // Amplitude mask or constant sample
		logic        fixedR0;    // r_h[0] and r_l[0] known in closed form
		logic [15:0] r0High;
		logic [15:0] r0Low;
	} testRow_t;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   sampleWrite;
	logic [AW-1:0]          sampleAddr;
	logic signed [15:0]     sampleData;
	logic                   start;
	logic [CW-1:0]          coefAddr;
	logic                   busy;
	logic                   done;
	logic signed [15:0]     rHigh;
	logic signed [15:0]     rLow;

	logic signed [15:0] frameX [0:WLEN-1];
	logic signed [15:0] expHigh [0:ORDER];
	logic signed [15:0] expLow [0:ORDER];
	integer seed = 86;
	int errors = 0;
	int testsFailed = 0;
	int doneCount = 0;
	int cycleCount = 0;

	`include "autocorrRefModel.svh"

	autocorrTop #(.ORDER(ORDER)) i_autocorrTop (
		.clk(clk), .reset(reset),
		.sampleWrite(sampleWrite), .sampleAddr(sampleAddr), .sampleData(sampleData),
		.start(start), .coefAddr(coefAddr),
		.busy(busy), .done(done), .rHigh(rHigh), .rLow(rLow)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		if (!reset && done)
			doneCount <= doneCount + 1;

	// Watchdog
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test table
	////////////////////////////////////////////////////////////
	function automatic testRow_t tableRow(input int idx);
		testRow_t row;
		row = '0;
		case (idx)
			0: row = '{KIND_ZERO,      16'h0000, 1'b1, 16'h4000, 16'h0000};  // Sum 1, norm 30
			1: row = '{KIND_RANDOM,    16'h00FF, 1'b0, 16'h0000, 16'h0000};
			2: row = '{KIND_RANDOM,    16'h03FF, 1'b0, 16'h0000, 16'h0000};
			3: row = '{KIND_ALTERNATE, 16'h0000, 1'b0, 16'h0000, 16'h0000};  // Rescale path
			default: row = '{KIND_CONST, 16'h0C00, 1'b0, 16'h0000, 16'h0000};
		endcase
		return row;
	endfunction

	function automatic string kindName(input logic [1:0] kind);
		case (kind)
			KIND_ZERO: return "zero";
			KIND_RANDOM: return "random";
			KIND_ALTERNATE: return "full-scale alternating";
			default: return "constant";
		endcase
	endfunction

	task automatic fillFrame(input testRow_t row);
		logic [31:0] rnd;
		logic signed [15:0] mag;
		for (int n = 0; n < WLEN; n++)
		begin
			case (row.kind)
				KIND_RANDOM:
				begin
					rnd = $random(seed);
					mag = rnd[15:0] & row.level;
					frameX[n] = rnd[16] ? -mag : mag;   // Sign from a spare bit
				end
				KIND_ALTERNATE:
					frameX[n] = n[0] ? 16'sh8000 : 16'sh7FFF;
				KIND_CONST:
					frameX[n] = row.level;
				default:
					frameX[n] = '0;
			endcase
		end
	endtask

	task automatic loadFrame();
		for (int n = 0; n < WLEN; n++)
		begin
			@(posedge clk);
			sampleWrite <= 1'b1;
			sampleAddr <= AW'(n);
			sampleData <= frameX[n];
		end
		@(posedge clk);
		sampleWrite <= 1'b0;
	endtask

	task automatic compareBank(input int t, input string phase);
		for (int k = 0; k <= ORDER; k++)
		begin
			@(posedge clk);
			coefAddr <= CW'(k);
			@(negedge clk);
			if (rHigh !== expHigh[k])
			begin
				$display("[FAIL] test %0d %s rHigh[%0d] got 0x%h expected 0x%h",
					t, phase, k, rHigh, expHigh[k]);
				errors++;
			end
			if (rLow !== expLow[k])
			begin
				$display("[FAIL] test %0d %s rLow[%0d] got 0x%h expected 0x%h",
					t, phase, k, rLow, expLow[k]);
				errors++;
			end
		end
	endtask

	// Alternating signs make every odd-lag product negative
	task automatic checkOddLagSign(input int t);
		for (int k = 1; k <= ORDER; k += 2)
		begin
			@(posedge clk);
			coefAddr <= CW'(k);
			@(negedge clk);
			if (rHigh >= 0)
			begin
				$display("[FAIL] test %0d rHigh[%0d] got 0x%h expected a negative value",
					t, k, rHigh);
				errors++;
			end
		end
	endtask

	task automatic runFrame(input int t);
		int doneBefore;
		doneBefore = doneCount;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		if (busy !== 1'b1)
		begin
			$display("[FAIL] test %0d busy got 0x%h expected 0x1 after start", t, busy);
			errors++;
		end
		repeat (1000) @(posedge clk);   // Lands in the first energy pass
		start <= 1'b1;                  // Must be ignored, frame is running
		@(posedge clk);
		start <= 1'b0;
		while (doneCount == doneBefore)
			@(negedge clk);
		repeat (20) @(negedge clk);
		if (doneCount != doneBefore + 1)
		begin
			$display("[FAIL] test %0d done pulses got 0x%h expected 0x1",
				t, doneCount - doneBefore);
			errors++;
		end
		if (busy !== 1'b0)
		begin
			$display("[FAIL] test %0d busy got 0x%h expected 0x0 after done", t, busy);
			errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		testRow_t row;
		int errBefore;
		reset = 1'b1;
		sampleWrite = 1'b0;
		sampleAddr = '0;
		sampleData = '0;
		start = 1'b0;
		coefAddr = '0;
		for (int k = 0; k <= ORDER; k++)
		begin
			expHigh[k] = '0;          // Bank cleared by reset
			expLow[k] = '0;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		if (busy !== 1'b0 || done !== 1'b0)
		begin
			$display("[FAIL] after reset busy 0x%h done 0x%h expected 0x0 0x0", busy, done);
			errors++;
		end
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			row = tableRow(t);
			errBefore = errors;
			fillFrame(row);
			loadFrame();
			compareBank(t, "before start");   // Previous frame still visible
			modelFrame();
			if (row.fixedR0)
			begin
				expHigh[0] = row.r0High;
				expLow[0] = row.r0Low;
			end
			runFrame(t);
			compareBank(t, "after done");
			if (row.kind == KIND_ALTERNATE)
				checkOddLagSign(t);
			if (errors == errBefore)
				$display("test %0d %s frame: ok", t, kindName(row.kind));
			else
			begin
				testsFailed++;
				$display("test %0d %s frame: %0d mismatches", t, kindName(row.kind),
					errors - errBefore);
			end
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			NUM_TESTS, NUM_TESTS - testsFailed, testsFailed, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/autocorrTop.sv ====
/*
 G.729 autocorrelation stage. Write 240 samples, pulse start, wait for done,
 then read ORDER+1 r_h / r_l pairs. Do not load samples while busy.
*/
`timescale 1ns/1ps
`default_nettype none

module autocorrTop #(
	parameter int ORDER = 10      // 1 to MAX_ORDER
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       sampleWrite,
	input  logic        [autocorrPkg::ADDR_W-1:0]      sampleAddr,
	input  logic signed [autocorrPkg::WORD_W-1:0]      sampleData,
	input  logic                                       start,
	input  logic        [autocorrPkg::COEF_ADDR_W-1:0] coefAddr,
	output logic                                       busy,
	output logic                                       done,
	output logic signed [autocorrPkg::WORD_W-1:0]      rHigh,
	output logic signed [autocorrPkg::WORD_W-1:0]      rLow
);

	// Buffer and ROM side
	logic        [autocorrPkg::ADDR_W-1:0]      bufAddr;
	logic                                       bufReadY;
	logic                                       bufWrite;
	logic signed [autocorrPkg::WORD_W-1:0]      bufWriteData;
	logic signed [autocorrPkg::WORD_W-1:0]      bufData;
	logic        [autocorrPkg::ADDR_W-1:0]      romIndex;
	logic signed [autocorrPkg::WORD_W-1:0]      romCoef;
	// Execute side
	logic                                       opStart;
	autocorrPkg::opCode_t                       opCode;
	logic signed [autocorrPkg::WORD_W-1:0]      opA;
	logic signed [autocorrPkg::WORD_W-1:0]      opB;
	logic signed [autocorrPkg::LONG_W-1:0]      opAcc;
	logic                                       opDone;
	logic signed [autocorrPkg::LONG_W-1:0]      opResult;
	logic                                       overflowSeen;
	// Result side
	logic                                       storeStrobe;
	logic        [autocorrPkg::COEF_ADDR_W-1:0] storeIndex;
	logic signed [autocorrPkg::LONG_W-1:0]      storeValue;

	autocorrSequencer #(.ORDER(ORDER)) i_autocorrSequencer (
		.clk(clk), .reset(reset), .start(start),
		.bufData(bufData), .romCoef(romCoef),
		.opDone(opDone), .opResult(opResult), .overflowSeen(overflowSeen),
		.busy(busy), .done(done),
		.bufAddr(bufAddr), .bufReadY(bufReadY),
		.bufWrite(bufWrite), .bufWriteData(bufWriteData), .romIndex(romIndex),
		.opStart(opStart), .opCode(opCode), .opA(opA), .opB(opB), .opAcc(opAcc),
		.storeStrobe(storeStrobe), .storeIndex(storeIndex), .storeValue(storeValue)
	);

	sampleBuffer i_sampleBuffer (
		.clk(clk), .sampleWrite(sampleWrite),
		.sampleAddr(sampleAddr), .sampleData(sampleData),
		.bufAddr(bufAddr), .bufReadY(bufReadY),
		.bufWrite(bufWrite), .bufWriteData(bufWriteData), .bufData(bufData)
	);

	hammingRom i_hammingRom (.romIndex(romIndex), .romCoef(romCoef));

	basicOpsUnit i_basicOpsUnit (
		.clk(clk), .reset(reset), .opStart(opStart), .opCode(opCode),
		.opA(opA), .opB(opB), .opAcc(opAcc),
		.opDone(opDone), .opResult(opResult), .overflowSeen(overflowSeen)
	);

	coefWriter #(.ORDER(ORDER)) i_coefWriter (
		.clk(clk), .reset(reset), .storeStrobe(storeStrobe),
		.storeIndex(storeIndex), .storeValue(storeValue),
		.coefAddr(coefAddr), .rHigh(rHigh), .rLow(rLow)
	);

endmodule

`default_nettype wire

// ==== src/coefWriter.sv ====
/*
 L_Extract and the r_h / r_l bank of ORDER+1 entries, cleared by reset.
 Reads are combinational; addresses past ORDER read as zero.
*/
`timescale 1ns/1ps
`default_nettype none

module coefWriter #(
	parameter int ORDER = 10
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       storeStrobe,
	input  logic        [autocorrPkg::COEF_ADDR_W-1:0] storeIndex,
	input  logic signed [autocorrPkg::LONG_W-1:0]      storeValue,
	input  logic        [autocorrPkg::COEF_ADDR_W-1:0] coefAddr,
	output logic signed [autocorrPkg::WORD_W-1:0]      rHigh,
	output logic signed [autocorrPkg::WORD_W-1:0]      rLow
);

	localparam int WW = autocorrPkg::WORD_W;
	localparam int LW = autocorrPkg::LONG_W;

	logic signed [WW-1:0] rhBank [0:ORDER];
	logic signed [WW-1:0] rlBank [0:ORDER];
	logic signed [WW-1:0] extHigh;
	logic signed [LW-1:0] halfValue;
	logic signed [LW-1:0] loFull;

	// lo = L_msu(value >> 1, hi, 16384), the msu doubling the product
	always_comb
	begin
		extHigh = storeValue[LW-1:WW];
		halfValue = storeValue >>> 1;
		loFull = halfValue - (LW'(extHigh) <<< 15);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int k = 0; k <= ORDER; k++)
			begin
				rhBank[k] <= '0;
				rlBank[k] <= '0;
			end
		end
		else if (storeStrobe && storeIndex <= ORDER)
		begin
			rhBank[storeIndex] <= extHigh;
			rlBank[storeIndex] <= loFull[WW-1:0];
		end
	end

	assign rHigh = (coefAddr <= ORDER) ? rhBank[coefAddr] : '0;
	assign rLow = (coefAddr <= ORDER) ? rlBank[coefAddr] : '0;

endmodule

`default_nettype wire

// ==== src/basicOpsUnit.sv ====
/*
 Bit-exact G.729 basic operations. mult_r, L_mac, shr and CLRSUM finish the cycle
 after opStart; norm_l and L_shl step one bit per cycle (1 to 32 cycles).
 L_shl shift counts come from opB[5:0] and must be non-negative.
*/
`timescale 1ns/1ps
`default_nettype none

module basicOpsUnit (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  opStart,
	input  autocorrPkg::opCode_t                  opCode,
	input  logic signed [autocorrPkg::WORD_W-1:0] opA,
	input  logic signed [autocorrPkg::WORD_W-1:0] opB,
	input  logic signed [autocorrPkg::LONG_W-1:0] opAcc,
	output logic                                  opDone,
	output logic signed [autocorrPkg::LONG_W-1:0] opResult,
	output logic                                  overflowSeen
);

	localparam int LW = autocorrPkg::LONG_W;
	localparam logic signed [LW-1:0] MAX_32 = 32'sh7FFF_FFFF;
	localparam logic signed [LW-1:0] MIN_32 = 32'sh8000_0000;

	logic signed [LW-1:0] product;
	logic signed [LW-1:0] rounded;
	logic signed [LW-1:0] macProd;
	logic        [LW:0]   macSum;      // One guard bit
	logic                 multOvf;
	logic                 macOvf;
	logic signed [LW-1:0] singleResult;
	logic                 iterOp;

	// Iterative state for norm_l and L_shl
	logic                 running;
	autocorrPkg::opCode_t runOp;
	logic signed [LW-1:0] work;
	logic        [5:0]    cnt;
	autocorrPkg::opCode_t curOp;
	logic signed [LW-1:0] curVal;
	logic        [5:0]    curCnt;
	logic        [5:0]    nextCnt;
	logic                 stepFinish;
	logic signed [LW-1:0] stepResult;

	////////////////////////////////////////////////////////////
	// Single-cycle datapath
	////////////////////////////////////////////////////////////
	always_comb
	begin
		product = opA * opB;
		rounded = product + 32'sd16384;
		multOvf = (product == 32'sh4000_0000);   // -32768 squared
		macProd = multOvf ? MAX_32 : (product <<< 1);
		macSum = {opAcc[LW-1], opAcc} + {macProd[LW-1], macProd};
		macOvf = multOvf || (macSum[LW] != macSum[LW-1]);
		iterOp = (opCode == autocorrPkg::OP_NORML) || (opCode == autocorrPkg::OP_SHL);
		case (opCode)
			autocorrPkg::OP_MULTR:
				singleResult = multOvf ? 32'sd32767 : (rounded >>> 15);
			autocorrPkg::OP_MAC:
				if (macSum[LW] != macSum[LW-1])
					singleResult = macSum[LW] ? MIN_32 : MAX_32;
				else
					singleResult = macSum[LW-1:0];
			autocorrPkg::OP_SHR2:
				singleResult = LW'(opA >>> 2);
			autocorrPkg::OP_CLRSUM:
				singleResult = 32'sd1;
			default:
				singleResult = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// One shift step, from the operands on start or from work
	////////////////////////////////////////////////////////////
	always_comb
	begin
		curOp = opStart ? opCode : runOp;
		curVal = opStart ? opAcc : work;
		if (opStart)
			curCnt = (opCode == autocorrPkg::OP_SHL) ? opB[5:0] : 6'd0;
		else
			curCnt = cnt;
		stepFinish = 1'b0;
		stepResult = curVal;
		if (curOp == autocorrPkg::OP_NORML)
		begin
			nextCnt = curCnt + 6'd1;   // Counts shifts taken
			if (curVal == 0)
			begin
				stepFinish = 1'b1;
				stepResult = '0;
			end
			else if (curVal[LW-1] != curVal[LW-2])
			begin
				stepFinish = 1'b1;
				stepResult = LW'(curCnt);
			end
		end
		else
		begin
			nextCnt = curCnt - 6'd1;   // Counts shifts left to do
			if (curCnt == 0)
				stepFinish = 1'b1;
			else if (curVal[LW-1] != curVal[LW-2])
			begin
				stepFinish = 1'b1;     // Next shift would overflow
				stepResult = curVal[LW-1] ? MIN_32 : MAX_32;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			opDone <= 1'b0;
			running <= 1'b0;
			overflowSeen <= 1'b0;
		end
		else
		begin
			opDone <= 1'b0;
			if (opStart && !iterOp)
			begin
				opDone <= 1'b1;
				opResult <= singleResult;
				if (opCode == autocorrPkg::OP_CLRSUM)
					overflowSeen <= 1'b0;
				else if (opCode == autocorrPkg::OP_MAC && macOvf)
					overflowSeen <= 1'b1;   // Sticky until next CLRSUM
			end
			else if (opStart || running)
			begin
				if (stepFinish)
				begin
					opDone <= 1'b1;
					opResult <= stepResult;
					running <= 1'b0;
				end
				else
				begin
					running <= 1'b1;
					runOp <= curOp;
					work <= curVal <<< 1;
					cnt <= nextCnt;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/autocorrSequencer.sv ====
/*
 Decode FSM for the autocorrelation loops. Issues one operation at a time and waits
 for opDone. ORDER may be 1 to MAX_ORDER; start is ignored unless idle.
*/
`timescale 1ns/1ps
`default_nettype none

module autocorrSequencer #(
	parameter int ORDER = 10
) (
	input  logic                                       clk,
	input  logic                                       reset,
	input  logic                                       start,
	input  logic signed [autocorrPkg::WORD_W-1:0]      bufData,
	input  logic signed [autocorrPkg::WORD_W-1:0]      romCoef,
	input  logic                                       opDone,
	input  logic signed [autocorrPkg::LONG_W-1:0]      opResult,
	input  logic                                       overflowSeen,
	output logic                                       busy,
	output logic                                       done,
	output logic        [autocorrPkg::ADDR_W-1:0]      bufAddr,
	output logic                                       bufReadY,
	output logic                                       bufWrite,
	output logic signed [autocorrPkg::WORD_W-1:0]      bufWriteData,
	output logic        [autocorrPkg::ADDR_W-1:0]      romIndex,
	output logic                                       opStart,
	output autocorrPkg::opCode_t                       opCode,
	output logic signed [autocorrPkg::WORD_W-1:0]      opA,
	output logic signed [autocorrPkg::WORD_W-1:0]      opB,
	output logic signed [autocorrPkg::LONG_W-1:0]      opAcc,
	output logic                                       storeStrobe,
	output logic        [autocorrPkg::COEF_ADDR_W-1:0] storeIndex,
	output logic signed [autocorrPkg::LONG_W-1:0]      storeValue
);

	localparam int AW = autocorrPkg::ADDR_W;
	localparam int WW = autocorrPkg::WORD_W;
	localparam int LW = autocorrPkg::LONG_W;
	localparam logic [AW-1:0] LAST_IDX = AW'(autocorrPkg::WINDOW_LEN - 1);
	localparam logic [AW-1:0] LAST_LAG = AW'(ORDER);

	autocorrPkg::seqState_t state;
	logic        [AW-1:0] i;
	logic        [AW-1:0] j;
	logic signed [LW-1:0] sum;
	logic        [4:0]    norm;          // Shared by every lag
	logic signed [WW-1:0] lagOperand;    // y[j+i]
	logic                 opPending;
	logic                 opIssue;
	logic                 sumClear;      // Next energy pass begins with CLRSUM
	logic                 iLast;
	logic                 lagLast;

	assign iLast = (i == LAST_IDX);
	assign lagLast = (AW'(i + j) == LAST_IDX);
	assign busy = (state != autocorrPkg::IDLE);
	assign done = (state == autocorrPkg::FINISH);
	assign storeStrobe = (state == autocorrPkg::STORE);
	assign storeIndex = i[autocorrPkg::COEF_ADDR_W-1:0];
	assign storeValue = sum;
	assign romIndex = i;
	assign opStart = opIssue && !opPending;

	////////////////////////////////////////////////////////////
	// Operation decode
	////////////////////////////////////////////////////////////
	always_comb
	begin
		bufAddr = i;
		bufReadY = 1'b1;
		bufWrite = 1'b0;
		bufWriteData = opResult[WW-1:0];
		opCode = autocorrPkg::OP_MAC;
		opA = bufData;
		opB = bufData;      // y[i] * y[i] by default
		opAcc = sum;
		opIssue = 1'b0;
		case (state)
			autocorrPkg::WIN_READ:
				bufReadY = 1'b0;
			autocorrPkg::WIN_OP:
			begin
				bufReadY = 1'b0;
				opCode = autocorrPkg::OP_MULTR;
				opB = romCoef;
				opIssue = 1'b1;
				bufWrite = opDone;     // y[i] lands as the product returns
			end
			autocorrPkg::ENERGY_OP:
			begin
				opCode = sumClear ? autocorrPkg::OP_CLRSUM : autocorrPkg::OP_MAC;
				opIssue = 1'b1;
			end
			autocorrPkg::SCALE_OP:
			begin
				opCode = autocorrPkg::OP_SHR2;
				opIssue = 1'b1;
				bufWrite = opDone;
			end
			autocorrPkg::NORM_OP:
			begin
				opCode = autocorrPkg::OP_NORML;
				opIssue = 1'b1;
			end
			autocorrPkg::SHIFT0_OP, autocorrPkg::LAG_SHIFT_OP:
			begin
				opCode = autocorrPkg::OP_SHL;
				opB = WW'(norm);
				opIssue = 1'b1;
			end
			autocorrPkg::LAG_READ_A:
				bufAddr = AW'(i + j);
			autocorrPkg::LAG_READ_B:
				bufAddr = j;
			autocorrPkg::LAG_OP:
			begin
				bufAddr = j;
				opB = lagOperand;
				opIssue = 1'b1;
			end
			default:
				opIssue = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Loop control
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= autocorrPkg::IDLE;
			i <= '0;
			j <= '0;
			opPending <= 1'b0;
			sumClear <= 1'b0;
		end
		else
		begin
			if (opStart)
				opPending <= 1'b1;
			else if (opDone)
				opPending <= 1'b0;

			case (state)
				autocorrPkg::IDLE:
					if (start)
					begin
						i <= '0;
						state <= autocorrPkg::WIN_READ;
					end
				autocorrPkg::WIN_READ:
					state <= autocorrPkg::WIN_OP;
				autocorrPkg::WIN_OP:
					if (opDone)
					begin
						if (iLast)
						begin
							i <= '0;
							sumClear <= 1'b1;
							state <= autocorrPkg::ENERGY_OP;
						end
						else
						begin
							i <= i + 1'b1;
							state <= autocorrPkg::WIN_READ;
						end
					end
				autocorrPkg::ENERGY_READ:
					state <= autocorrPkg::ENERGY_OP;
				autocorrPkg::ENERGY_OP:
					if (opDone)
					begin
						sum <= opResult;
						if (sumClear)
						begin
							sumClear <= 1'b0;
							state <= autocorrPkg::ENERGY_READ;
						end
						else if (iLast)
						begin
							i <= '0;
							// Saturated pass means y gets scaled down and redone
							state <= overflowSeen ? autocorrPkg::SCALE_READ : autocorrPkg::NORM_OP;
						end
						else
						begin
							i <= i + 1'b1;
							state <= autocorrPkg::ENERGY_READ;
						end
					end
				autocorrPkg::SCALE_READ:
					state <= autocorrPkg::SCALE_OP;
				autocorrPkg::SCALE_OP:
					if (opDone)
					begin
						if (iLast)
						begin
							i <= '0;
							sumClear <= 1'b1;
							state <= autocorrPkg::ENERGY_OP;
						end
						else
						begin
							i <= i + 1'b1;
							state <= autocorrPkg::SCALE_READ;
						end
					end
				autocorrPkg::NORM_OP:
					if (opDone)
					begin
						norm <= opResult[4:0];
						state <= autocorrPkg::SHIFT0_OP;
					end
				autocorrPkg::SHIFT0_OP, autocorrPkg::LAG_SHIFT_OP:
					if (opDone)
					begin
						sum <= opResult;
						state <= autocorrPkg::STORE;
					end
				autocorrPkg::STORE:
					if (i == LAST_LAG)
						state <= autocorrPkg::FINISH;
					else
					begin
						i <= i + 1'b1;
						j <= '0;
						sum <= '0;      // Lags start from zero
						state <= autocorrPkg::LAG_READ_A;
					end
				autocorrPkg::LAG_READ_A:
					state <= autocorrPkg::LAG_READ_B;
				autocorrPkg::LAG_READ_B:
				begin
					lagOperand <= bufData;
					state <= autocorrPkg::LAG_OP;
				end
				autocorrPkg::LAG_OP:
					if (opDone)
					begin
						sum <= opResult;
						if (lagLast)
							state <= autocorrPkg::LAG_SHIFT_OP;
						else
						begin
							j <= j + 1'b1;
							state <= autocorrPkg::LAG_READ_A;
						end
					end
				default:
					state <= autocorrPkg::IDLE;   // FINISH
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== src/sampleBuffer.sv ====
/*
 Frame RAM with an input bank x (host writes) and a windowed bank y (sequencer writes).
 Reads are registered, one cycle after bufAddr. Loading x while a frame runs corrupts it.
*/
`timescale 1ns/1ps
`default_nettype none

module sampleBuffer (
	input  logic                                  clk,
	input  logic                                  sampleWrite,
	input  logic        [autocorrPkg::ADDR_W-1:0] sampleAddr,
	input  logic signed [autocorrPkg::WORD_W-1:0] sampleData,
	input  logic        [autocorrPkg::ADDR_W-1:0] bufAddr,
	input  logic                                  bufReadY,
	input  logic                                  bufWrite,
	input  logic signed [autocorrPkg::WORD_W-1:0] bufWriteData,
	output logic signed [autocorrPkg::WORD_W-1:0] bufData
);

	logic signed [autocorrPkg::WORD_W-1:0] xMem [0:autocorrPkg::WINDOW_LEN-1];
	logic signed [autocorrPkg::WORD_W-1:0] yMem [0:autocorrPkg::WINDOW_LEN-1];

	always_ff @(posedge clk)
	begin
		if (sampleWrite && sampleAddr < autocorrPkg::WINDOW_LEN)
			xMem[sampleAddr] <= sampleData;     // Host side, x only
		if (bufWrite && bufAddr < autocorrPkg::WINDOW_LEN)
			yMem[bufAddr] <= bufWriteData;      // Sequencer side, y only
		if (bufReadY)
			bufData <= yMem[bufAddr];
		else
			bufData <= xMem[bufAddr];
	end

endmodule

`default_nettype wire

// ==== src/hammingRom.sv ====
/*
 G.729 hamwindow table in Q15, purely combinational.
 Indices past the last sample read as zero.
*/
`timescale 1ns/1ps
`default_nettype none

module hammingRom (
	input  logic        [autocorrPkg::ADDR_W-1:0] romIndex,
	output logic signed [autocorrPkg::WORD_W-1:0] romCoef
);

	// First 200 points rise as a Hamming half, the last 40 fall as a cosine
	localparam logic signed [15:0] HAM_TABLE [0:239] = '{
		2621,  2623,  2629,  2638,  2651,  2668,  2689,  2713,  2741,  2772,
		2808,  2847,  2890,  2936,  2986,  3040,  3097,  3158,  3223,  3291,
		3363,  3438,  3517,  3599,  3685,  3774,  3867,  3963,  4063,  4166,
		4272,  4382,  4495,  4611,  4731,  4853,  4979,  5108,  5240,  5376,
		5514,  5655,  5800,  5947,  6097,  6250,  6406,  6565,  6726,  6890,
		7057,  7227,  7399,  7573,  7750,  7930,  8112,  8296,  8483,  8672,
		8863,  9057,  9252,  9450,  9650,  9852, 10055, 10261, 10468, 10677,
		10888, 11101, 11315, 11531, 11748, 11967, 12187, 12409, 12632, 12856,
		13082, 13308, 13536, 13764, 13994, 14225, 14456, 14688, 14921, 15155,
		15389, 15624, 15859, 16095, 16331, 16568, 16805, 17042, 17279, 17516,
		17754, 17991, 18228, 18465, 18702, 18939, 19175, 19411, 19647, 19882,
		20117, 20350, 20584, 20816, 21048, 21279, 21509, 21738, 21967, 22194,
		22420, 22644, 22868, 23090, 23311, 23531, 23749, 23965, 24181, 24394,
		24606, 24816, 25024, 25231, 25435, 25638, 25839, 26037, 26234, 26428,
		26621, 26811, 26999, 27184, 27368, 27548, 27727, 27903, 28076, 28247,
		28415, 28581, 28743, 28903, 29061, 29215, 29367, 29515, 29661, 29804,
		29944, 30081, 30214, 30345, 30472, 30597, 30718, 30836, 30950, 31062,
		31170, 31274, 31376, 31474, 31568, 31659, 31747, 31831, 31911, 31988,
		32062, 32132, 32198, 32261, 32320, 32376, 32428, 32476, 32521, 32561,
		32599, 32632, 32662, 32688, 32711, 32729, 32744, 32755, 32763, 32767,
		32767, 32741, 32665, 32537, 32359, 32129, 31850, 31521, 31143, 30716,
		30242, 29720, 29151, 28538, 27879, 27177, 26433, 25647, 24821, 23957,
		23055, 22117, 21145, 20139, 19102, 18036, 16941, 15820, 14674, 13505,
		12315, 11106,  9879,  8637,  7381,  6114,  4838,  3554,  2264,   971
	};

	assign romCoef = (romIndex < autocorrPkg::WINDOW_LEN) ? HAM_TABLE[romIndex] : '0;

endmodule

`default_nettype wire

// ==== src/autocorrPkg.sv ====
/*
 Shared widths and encodings for the G.729 autocorrelation stage.
 WINDOW_LEN is fixed at 240 because the Hamming table only exists for that length.
*/
`default_nettype none

package autocorrPkg;

	localparam int WORD_W      = 16;                     // Q15 word
	localparam int LONG_W      = 32;                     // Q31 word
	localparam int WINDOW_LEN  = 240;
	localparam int ADDR_W      = 8;
	localparam int MAX_ORDER   = 15;                     // Deepest bank coefWriter can hold
	localparam int COEF_ADDR_W = $clog2(MAX_ORDER + 1);

	// Operations understood by basicOpsUnit
	typedef enum logic [2:0] {
		OP_MULTR,
		OP_MAC,
		OP_SHR2,
		OP_NORML,
		OP_SHL,
		OP_CLRSUM   // sum = 1, clears overflow
	} opCode_t;

	typedef enum logic [3:0] {
		IDLE,
		WIN_READ,
		WIN_OP,
		ENERGY_READ,
		ENERGY_OP,
		SCALE_READ,
		SCALE_OP,
		NORM_OP,
		SHIFT0_OP,
		LAG_READ_A,
		LAG_READ_B,
		LAG_OP,
		LAG_SHIFT_OP,
		STORE,
		FINISH
	} seqState_t;

endpackage

`default_nettype wire
